//--- rtl/video_pkg.sv
`default_nettype none

package video_pkg;

    // Line buffer spans 512 pixel positions
    localparam int LINE_AW = 9;

    // Color index 0 never reaches the screen
    localparam logic [3:0] TRANSPARENT = 4'd0;

    // Pixel word as stored in the line buffer
    // Palette in the top bits so the mixer can index a CLUT directly
    typedef struct packed {
        logic [5:0] pal;
        logic [1:0] prio;
        logic [3:0] color;
    } pixel_t;

endpackage

`default_nettype wire

//--- rtl/obj_pkg.sv
`default_nettype none

package obj_pkg;

    // 64 entries of 4 words each
    localparam int TABLE_AW = 8;

    // Word order inside one table entry
    localparam logic [1:0] WORD_SPAN   = 2'd0;
    localparam logic [1:0] WORD_XPOS   = 2'd1;
    localparam logic [1:0] WORD_OFFSET = 2'd2;
    localparam logic [1:0] WORD_ATTR   = 2'd3;

    // High byte of the span word that closes the list
    localparam logic [7:0] TERM_MARK = 8'hFF;

    // Word 0 seen either as a line span or as a list terminator
    typedef union packed {
        struct packed {
            logic [7:0] bottom;
            logic [7:0] top;
        } span;
        struct packed {
            logic [7:0] mark;
            logic [7:0] rsvd;
        } term;
    } span_u;

    // Word 3
    typedef struct packed {
        logic       hflip;
        logic [1:0] prio;
        logic [5:0] pal;
        logic [3:0] bank;
        logic [2:0] unused;
    } attr_t;

    // One sprite row handed from scanner to drawer
    typedef struct packed {
        logic [8:0]  xpos;
        logic [15:0] row;
        logic [3:0]  bank;
        logic [5:0]  pal;
        logic [1:0]  prio;
        logic        hflip;
    } draw_cmd_t;

endpackage

`default_nettype wire

//--- rtl/obj_draw_if.sv
`default_nettype none

interface obj_draw_if;
    import obj_pkg::*;

    // Four-phase request from the scanner
    logic      req;
    // Row fully written into the line buffer
    logic      ack;
    // Held while req or ack is high
    draw_cmd_t cmd;

    modport scanner (
        output req,
        output cmd,
        input  ack
    );

    modport drawer (
        input  req,
        input  cmd,
        output ack
    );

endinterface

`default_nettype wire

//--- rtl/obj_ram.sv
`default_nettype none

module obj_ram (
    input  wire                          clk,
    input  wire                          arst_n,
    input  wire                          cpu_cs,
    input  wire                          cpu_we,
    input  wire [obj_pkg::TABLE_AW-1:0]  cpu_addr,
    input  wire [15:0]                   cpu_dout,
    input  wire [1:0]                    dsn,
    input  wire [obj_pkg::TABLE_AW-1:0]  tbl_addr,
    output logic [15:0]                  cpu_din,
    output logic [15:0]                  tbl_dout
);
    import obj_pkg::*;

    localparam int WORDS = 2 ** TABLE_AW;

    logic [15:0] mem [0:WORDS-1];
    logic        wr_en;

    // Chip select qualifies every write
    assign wr_en = cpu_cs && cpu_we;

    // CPU side, byte lanes active low
    always_ff @(posedge clk) begin
        if (wr_en && !dsn[1]) begin
            mem[cpu_addr][15:8] <= cpu_dout[15:8];
        end
        if (wr_en && !dsn[0]) begin
            mem[cpu_addr][7:0] <= cpu_dout[7:0];
        end
        // Old data on a same-cycle write
        cpu_din <= mem[cpu_addr];
    end

    // Scanner side is read only
    always_ff @(posedge clk) begin
        tbl_dout <= mem[tbl_addr];
    end

    // A stray write strobe without chip select leaves the table alone
    assert property (@(posedge clk) disable iff (!arst_n)
        (cpu_we && !cpu_cs) |=> (mem[$past(cpu_addr)] == $past(mem[cpu_addr])));

endmodule

`default_nettype wire

//--- rtl/obj_scan.sv
`default_nettype none

module obj_scan (
    input  wire                          clk,
    input  wire                          arst_n,
    input  wire                          hstart,
    input  wire [8:0]                    vrender,
    input  wire [15:0]                   tbl_dout,
    output logic [obj_pkg::TABLE_AW-1:0] tbl_addr,
    obj_draw_if.scanner                  draw
);
    import obj_pkg::*;

    localparam int IDX_W = TABLE_AW - 2;

    localparam logic [2:0] S_IDLE = 3'd0;
    localparam logic [2:0] S_ADDR = 3'd1;
    localparam logic [2:0] S_DATA = 3'd2;
    localparam logic [2:0] S_REQ  = 3'd3;
    localparam logic [2:0] S_ACK  = 3'd4;

    logic [2:0]       state;
    logic [IDX_W-1:0] idx;
    logic [1:0]       wsel;
    logic [8:0]       line;
    logic [8:0]       rel;
    span_u            span;
    attr_t            attr;
    logic             start;
    logic             hit;
    logic             last;

    // Same table word, two views
    assign span = tbl_dout;
    assign attr = tbl_dout;

    assign tbl_addr = {idx, wsel};
    // hstart only counts while idle
    assign start = (state == S_IDLE) && hstart;
    // Bottom line is exclusive
    assign hit = ({1'b0, span.span.top} <= line) && (line < {1'b0, span.span.bottom});
    assign last = &idx;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= S_IDLE;
            idx      <= '0;
            wsel     <= WORD_SPAN;
            draw.req <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        idx   <= '0;
                        wsel  <= WORD_SPAN;
                        state <= S_ADDR;
                    end
                end
                // Table read latency
                S_ADDR: state <= S_DATA;
                S_DATA: begin
                    case (wsel)
                        WORD_SPAN: begin
                            if (span.term.mark == TERM_MARK) begin
                                state <= S_IDLE;
                            end else if (hit) begin
                                wsel  <= WORD_XPOS;
                                state <= S_ADDR;
                            end else if (last) begin
                                state <= S_IDLE;
                            end else begin
                                idx   <= idx + 1'b1;
                                state <= S_ADDR;
                            end
                        end
                        // Command complete once attributes are in
                        WORD_ATTR: begin
                            draw.req <= 1'b1;
                            state    <= S_REQ;
                        end
                        default: begin
                            wsel  <= wsel + 2'd1;
                            state <= S_ADDR;
                        end
                    endcase
                end
                S_REQ: begin
                    if (draw.ack) begin
                        draw.req <= 1'b0;
                        state    <= S_ACK;
                    end
                end
                // Drawer must release ack before cmd moves
                S_ACK: begin
                    if (!draw.ack) begin
                        wsel <= WORD_SPAN;
                        if (last) begin
                            state <= S_IDLE;
                        end else begin
                            idx   <= idx + 1'b1;
                            state <= S_ADDR;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Command fields, loaded word by word
    always_ff @(posedge clk) begin
        if (start) begin
            line <= vrender + 9'd1;
        end
        if (state == S_DATA) begin
            case (wsel)
                WORD_SPAN:   rel <= line - {1'b0, span.span.top};
                WORD_XPOS:   draw.cmd.xpos <= tbl_dout[8:0];
                // Four graphics words per sprite row
                WORD_OFFSET: draw.cmd.row <= tbl_dout + {5'd0, rel, 2'b00};
                default: begin
                    draw.cmd.bank  <= attr.bank;
                    draw.cmd.pal   <= attr.pal;
                    draw.cmd.prio  <= attr.prio;
                    draw.cmd.hflip <= attr.hflip;
                end
            endcase
        end
    end

    // Drawer sees a steady command for the whole request
    assert property (@(posedge clk) disable iff (!arst_n)
        draw.req |=> (!draw.req || $stable(draw.cmd)));

endmodule

`default_nettype wire

//--- rtl/obj_draw.sv
`default_nettype none

module obj_draw (
    input  wire                           clk,
    input  wire                           arst_n,
    input  wire                           gfx_ack,
    input  wire [15:0]                    gfx_data,
    output logic                          gfx_req,
    output logic [19:0]                   gfx_addr,
    obj_draw_if.drawer                    cmd,
    output logic                          buf_we,
    output logic [video_pkg::LINE_AW-1:0] buf_addr,
    output video_pkg::pixel_t             buf_data
);
    import video_pkg::*;

    localparam logic [2:0] D_IDLE  = 3'd0;
    localparam logic [2:0] D_WAIT  = 3'd1;
    localparam logic [2:0] D_FETCH = 3'd2;
    localparam logic [2:0] D_WRITE = 3'd3;
    localparam logic [2:0] D_DONE  = 3'd4;

    logic [2:0]  state;
    logic [1:0]  word;
    logic [1:0]  pix;
    logic [15:0] data_q;
    logic [3:0]  n;
    logic [3:0]  col;
    logic [3:0]  color;

    // Pixel index within the 16-wide row
    assign n = {word, pix};
    // Mirrored column is 15 - n
    assign col = cmd.cmd.hflip ? ~n : n;
    // Leftmost pixel sits in the top nibble
    assign color = data_q[15:12];

    // Bank on top of the 16-bit word address
    assign gfx_addr = {cmd.cmd.bank, cmd.cmd.row + {14'd0, word}};

    // Line-buffer write port
    assign buf_we   = (state == D_WRITE) && (color != TRANSPARENT);
    // Wraps at 512
    assign buf_addr = cmd.cmd.xpos + {5'd0, col};
    assign buf_data = '{pal: cmd.cmd.pal, prio: cmd.cmd.prio, color: color};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= D_IDLE;
            word    <= 2'd0;
            pix     <= 2'd0;
            gfx_req <= 1'b0;
            cmd.ack <= 1'b0;
        end else begin
            case (state)
                D_IDLE: begin
                    if (cmd.req) begin
                        word  <= 2'd0;
                        state <= D_WAIT;
                    end
                end
                // Memory must finish the previous handshake first
                D_WAIT: begin
                    if (!gfx_ack) begin
                        gfx_req <= 1'b1;
                        state   <= D_FETCH;
                    end
                end
                D_FETCH: begin
                    if (gfx_ack) begin
                        gfx_req <= 1'b0;
                        pix     <= 2'd0;
                        state   <= D_WRITE;
                    end
                end
                // One pixel per cycle
                D_WRITE: begin
                    pix <= pix + 2'd1;
                    if (pix == 2'd3) begin
                        if (word == 2'd3) begin
                            cmd.ack <= 1'b1;
                            state   <= D_DONE;
                        end else begin
                            word  <= word + 2'd1;
                            state <= D_WAIT;
                        end
                    end
                end
                D_DONE: begin
                    if (!cmd.req) begin
                        cmd.ack <= 1'b0;
                        state   <= D_IDLE;
                    end
                end
                default: state <= D_IDLE;
            endcase
        end
    end

    // Fetched word, shifted a nibble per written pixel
    always_ff @(posedge clk) begin
        if (state == D_FETCH && gfx_ack) begin
            data_q <= gfx_data;
        end else if (state == D_WRITE) begin
            data_q <= {data_q[11:0], 4'd0};
        end
    end

    // Address held until memory has taken the request
    assert property (@(posedge clk) disable iff (!arst_n)
        gfx_req |=> (!gfx_req || $stable(gfx_addr)));

endmodule

`default_nettype wire

//--- rtl/obj_line_buffer.sv
`default_nettype none

module obj_line_buffer #(
    parameter int DEPTH_AW = 9
) (
    input  wire                    clk,
    input  wire                    arst_n,
    input  wire                    lhbl,
    input  wire                    pxl_cen,
    input  wire                    we,
    input  wire [DEPTH_AW-1:0]     wr_addr,
    input  wire video_pkg::pixel_t wr_data,
    output video_pkg::pixel_t      pxl
);
    import video_pkg::*;

    localparam int DEPTH = 2 ** DEPTH_AW;

    // Both halves in one array, bank bit on top
    pixel_t              ram [0:2*DEPTH-1];
    logic                bank;
    logic                lhbl_q;
    logic [DEPTH_AW-1:0] rd_cnt;
    logic                rd_en;
    logic                wr_en;
    logic [DEPTH_AW:0]   wr_ptr;
    logic [DEPTH_AW:0]   rd_ptr;

    assign rd_en = lhbl && pxl_cen;
    // Color 0 keeps whatever lies underneath
    assign wr_en = we && (wr_data.color != TRANSPARENT);
    assign wr_ptr = {bank, wr_addr};
    assign rd_ptr = {~bank, rd_cnt};

    // Drawing into one half, erasing the other behind the read
    always_ff @(posedge clk) begin
        if (wr_en) begin
            ram[wr_ptr] <= wr_data;
        end
        if (rd_en) begin
            ram[rd_ptr] <= '0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bank   <= 1'b0;
            lhbl_q <= 1'b0;
            rd_cnt <= '0;
            pxl    <= '0;
        end else begin
            lhbl_q <= lhbl;
            // Halves swap when blanking begins
            if (lhbl_q && !lhbl) begin
                bank <= ~bank;
            end
            if (!lhbl) begin
                rd_cnt <= '0;
            end else if (pxl_cen) begin
                pxl    <= ram[rd_ptr];
                rd_cnt <= rd_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/obj_engine.sv
`default_nettype none

module obj_engine (
    input  wire                          clk,
    input  wire                          arst_n,
    input  wire                          cpu_cs,
    input  wire                          cpu_we,
    input  wire [obj_pkg::TABLE_AW-1:0]  cpu_addr,
    input  wire [15:0]                   cpu_dout,
    input  wire [1:0]                    dsn,
    output logic [15:0]                  cpu_din,
    output logic                         gfx_req,
    output logic [19:0]                  gfx_addr,
    input  wire [15:0]                   gfx_data,
    input  wire                          gfx_ack,
    input  wire                          hstart,
    input  wire                          lhbl,
    input  wire                          pxl_cen,
    input  wire [8:0]                    vrender,
    output video_pkg::pixel_t            pxl
);
    import obj_pkg::*;
    import video_pkg::*;

    // Table read port
    logic [TABLE_AW-1:0] tbl_addr;
    logic [15:0]         tbl_dout;

    // Drawer to line buffer
    logic               buf_we;
    logic [LINE_AW-1:0] buf_addr;
    pixel_t             buf_data;

    obj_draw_if u_draw_if ();

    obj_ram u_ram (
        .clk      (clk),
        .arst_n   (arst_n),
        .cpu_cs   (cpu_cs),
        .cpu_we   (cpu_we),
        .cpu_addr (cpu_addr),
        .cpu_dout (cpu_dout),
        .dsn      (dsn),
        .tbl_addr (tbl_addr),
        .cpu_din  (cpu_din),
        .tbl_dout (tbl_dout)
    );

    obj_scan u_scan (
        .clk      (clk),
        .arst_n   (arst_n),
        .hstart   (hstart),
        .vrender  (vrender),
        .tbl_dout (tbl_dout),
        .tbl_addr (tbl_addr),
        .draw     (u_draw_if.scanner)
    );

    obj_draw u_draw (
        .clk      (clk),
        .arst_n   (arst_n),
        .gfx_ack  (gfx_ack),
        .gfx_data (gfx_data),
        .gfx_req  (gfx_req),
        .gfx_addr (gfx_addr),
        .cmd      (u_draw_if.drawer),
        .buf_we   (buf_we),
        .buf_addr (buf_addr),
        .buf_data (buf_data)
    );

    obj_line_buffer #(
        .DEPTH_AW (LINE_AW)
    ) u_line (
        .clk     (clk),
        .arst_n  (arst_n),
        .lhbl    (lhbl),
        .pxl_cen (pxl_cen),
        .we      (buf_we),
        .wr_addr (buf_addr),
        .wr_data (buf_data),
        .pxl     (pxl)
    );

endmodule

`default_nettype wire

//--- testbench/obj_checker.sv
`default_nettype none

module obj_checker (
    input  wire        clk,
    input  wire        lhbl,
    input  wire        pxl_cen,
    input  wire [11:0] pxl,
    input  wire [15:0] cpu_din,
    output int         pix_errs,
    output int         cpu_errs
);
    localparam int LINE_PIXELS = 320;

    // Expected active line, loaded before each line starts
    logic [11:0] exp_line [0:LINE_PIXELS-1];
    string       name;
    logic        armed;
    logic        rd_seen;
    int          idx;

    initial begin
        pix_errs = 0;
        cpu_errs = 0;
        armed    = 1'b0;
        rd_seen  = 1'b0;
        idx      = 0;
    end

    task automatic load_pixel(input int pos, input logic [11:0] value);
        exp_line[pos] = value;
    endtask

    task automatic start_line(input string test_name);
        name  = test_name;
        idx   = 0;
        armed = 1'b1;
    endtask

    // Comparing stops until the next line is loaded
    task automatic end_line();
        armed = 1'b0;
    endtask

    // Called one cycle after the address went out
    task automatic check_cpu(input string test_name, input logic [15:0] expected);
        if (cpu_din !== expected) begin
            $display("Error %s: expected %h, actual %h", test_name, expected, cpu_din);
            cpu_errs++;
        end
    endtask

    // Read strobe at this edge, new pixel on pxl after it
    always @(posedge clk) begin
        rd_seen <= lhbl && pxl_cen;
    end

    always @(negedge clk) begin
        if (armed && rd_seen && idx < LINE_PIXELS) begin
            if (pxl !== exp_line[idx]) begin
                $display("Error %s: pixel %0d expected %h, actual %h",
                         name, idx, exp_line[idx], pxl);
                pix_errs++;
            end
            idx++;
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_obj_engine.sv
`default_nettype none

module tb_obj_engine;

    localparam int         NROWS       = 7;
    localparam int         LINE_PIXELS = 320;
    localparam int         SCAN_CYCLES = 6000;
    localparam logic [7:0] LANE_ADDR   = 8'hF6;

    typedef struct packed {
        logic [7:0]  top;
        logic [7:0]  bottom;
        logic [8:0]  x;
        logic [15:0] offset;
        logic [3:0]  bank;
        logic [5:0]  pal;
        logic [1:0]  prio;
        logic        hflip;
    } sprite_t;

    // Covers every line, only ever placed behind a terminator
    localparam sprite_t DECOY = '{8'd0, 8'd254, 9'd240, 16'h0400, 4'd5, 6'h3F, 2'd3, 1'b0};

    logic        clk;
    logic        arst_n;
    logic        cpu_cs;
    logic        cpu_we;
    logic [7:0]  cpu_addr;
    logic [15:0] cpu_dout;
    logic [1:0]  dsn;
    logic [15:0] cpu_din;
    logic        gfx_req;
    logic [19:0] gfx_addr;
    logic [15:0] gfx_data;
    logic        gfx_ack;
    logic        hstart;
    logic        lhbl;
    logic        pxl_cen;
    logic [8:0]  vrender;
    logic [11:0] pxl;
    int          pix_errs;
    int          cpu_errs;
    int          timeouts;

    // Graphics memory model
    logic [31:0] rng;
    logic        gfx_busy;
    int          gfx_wait;

    // Stimulus table, one row per test line
    string   row_name [NROWS];
    int      row_line [NROWS];
    int      row_cnt  [NROWS];
    logic    row_term [NROWS];
    sprite_t row_spr  [NROWS][4];

    obj_engine uut (
        .clk      (clk),
        .arst_n   (arst_n),
        .cpu_cs   (cpu_cs),
        .cpu_we   (cpu_we),
        .cpu_addr (cpu_addr),
        .cpu_dout (cpu_dout),
        .dsn      (dsn),
        .cpu_din  (cpu_din),
        .gfx_req  (gfx_req),
        .gfx_addr (gfx_addr),
        .gfx_data (gfx_data),
        .gfx_ack  (gfx_ack),
        .hstart   (hstart),
        .lhbl     (lhbl),
        .pxl_cen  (pxl_cen),
        .vrender  (vrender),
        .pxl      (pxl)
    );

    obj_checker chk (
        .clk      (clk),
        .lhbl     (lhbl),
        .pxl_cen  (pxl_cen),
        .pxl      (pxl),
        .cpu_din  (cpu_din),
        .pix_errs (pix_errs),
        .cpu_errs (cpu_errs)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] v);
        logic [31:0] x;
        x = v;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // ROM contents hashed from the full 20-bit address
    function automatic logic [15:0] gfx_word(input logic [19:0] addr);
        logic [31:0] h;
        h = xorshift({12'd0, addr});
        return h[15:0];
    endfunction

    // Byte lanes are active low
    function automatic logic [15:0] lane_merge(input logic [15:0] old, input logic [15:0] data,
                                               input logic [1:0] lanes);
        logic [15:0] res;
        res = old;
        if (!lanes[1]) begin
            res[15:8] = data[15:8];
        end
        if (!lanes[0]) begin
            res[7:0] = data[7:0];
        end
        return res;
    endfunction

    // Four-phase ROM, answers 1 to 4 cycles after the request
    always @(negedge clk) begin
        if (gfx_ack) begin
            if (!gfx_req) begin
                gfx_ack = 1'b0;
            end
        end else if (gfx_busy) begin
            gfx_wait--;
            if (gfx_wait == 0) begin
                gfx_data = gfx_word(gfx_addr);
                gfx_ack  = 1'b1;
                gfx_busy = 1'b0;
            end
        end else if (gfx_req) begin
            rng      = xorshift(rng);
            gfx_wait = 1 + int'(rng[1:0]);
            gfx_busy = 1'b1;
        end
    end

    task automatic set_row(input int r, input string name, input int line, input int cnt,
                           input logic term);
        row_name[r] = name;
        row_line[r] = line;
        row_cnt[r]  = cnt;
        row_term[r] = term;
    endtask

    task automatic fill_table();
        set_row(0, "single_hit", 40, 1, 1'b0);
        row_spr[0][0] = '{8'd33, 8'd49, 9'd20, 16'h0100, 4'd3, 6'h15, 2'd2, 1'b0};
        // Bottom line is exclusive, second one starts below
        set_row(1, "span_miss", 60, 2, 1'b0);
        row_spr[1][0] = '{8'd50, 8'd60, 9'd40, 16'h0180, 4'd3, 6'h15, 2'd2, 1'b0};
        row_spr[1][1] = '{8'd61, 8'd70, 9'd80, 16'h0180, 4'd3, 6'h15, 2'd2, 1'b0};
        set_row(2, "hflip", 40, 1, 1'b0);
        row_spr[2][0] = '{8'd33, 8'd49, 9'd100, 16'h0100, 4'd3, 6'h15, 2'd2, 1'b1};
        // Four sprites stacked four pixels apart
        set_row(3, "overlap", 80, 4, 1'b0);
        row_spr[3][0] = '{8'd70, 8'd90, 9'd50, 16'h0200, 4'd1, 6'h01, 2'd0, 1'b0};
        row_spr[3][1] = '{8'd75, 8'd85, 9'd54, 16'h0300, 4'd2, 6'h02, 2'd3, 1'b1};
        row_spr[3][2] = '{8'd80, 8'd81, 9'd58, 16'h0240, 4'd6, 6'h2A, 2'd1, 1'b0};
        row_spr[3][3] = '{8'd64, 8'd96, 9'd62, 16'h0010, 4'd9, 6'h3C, 2'd2, 1'b1};
        set_row(4, "terminator", 120, 2, 1'b1);
        row_spr[4][0] = '{8'd100, 8'd140, 9'd200, 16'h0500, 4'd4, 6'h07, 2'd1, 1'b0};
        row_spr[4][1] = '{8'd119, 8'd121, 9'd160, 16'h0600, 4'd7, 6'h11, 2'd3, 1'b1};
        // Two empty lines read both halves back
        set_row(5, "empty_a", 10, 0, 1'b1);
        set_row(6, "empty_b", 11, 0, 1'b0);
    endtask

    // Caller sits on a falling edge
    task automatic cpu_write(input logic [7:0] addr, input logic [15:0] data,
                             input logic [1:0] lanes);
        cpu_cs   = 1'b1;
        cpu_we   = 1'b1;
        cpu_addr = addr;
        cpu_dout = data;
        dsn      = lanes;
        @(negedge clk);
        cpu_cs = 1'b0;
        cpu_we = 1'b0;
        dsn    = 2'b11;
    endtask

    task automatic cpu_read_check(input string name, input logic [15:0] expected);
        cpu_cs   = 1'b1;
        cpu_we   = 1'b0;
        cpu_addr = LANE_ADDR;
        @(negedge clk);
        chk.check_cpu(name, expected);
        cpu_cs = 1'b0;
    endtask

    task automatic cpu_lane_test();
        logic [15:0] word;
        word = 16'h1234;
        cpu_write(LANE_ADDR, word, 2'b00);
        cpu_read_check("full_word", word);
        cpu_write(LANE_ADDR, 16'hABCD, 2'b01);
        word = lane_merge(word, 16'hABCD, 2'b01);
        cpu_read_check("lane_high", word);
        cpu_write(LANE_ADDR, 16'h5E6F, 2'b10);
        word = lane_merge(word, 16'h5E6F, 2'b10);
        cpu_read_check("lane_low", word);
        // Write strobe without chip select
        cpu_we   = 1'b1;
        cpu_addr = LANE_ADDR;
        cpu_dout = 16'h0000;
        dsn      = 2'b00;
        @(negedge clk);
        cpu_we = 1'b0;
        dsn    = 2'b11;
        cpu_read_check("no_cs", word);
    endtask

    // Entries 0 to 5, decoy behind the terminator
    task automatic load_row(input int r);
        sprite_t s;
        int      i;
        for (i = 0; i < 6; i++) begin
            if (i < row_cnt[r]) begin
                s = row_spr[r][i];
            end else if (i == 5 && row_term[r]) begin
                s = DECOY;
            end else begin
                s = '0;
            end
            cpu_write(8'(4 * i), {s.bottom, s.top}, 2'b00);
            cpu_write(8'(4 * i + 1), {7'd0, s.x}, 2'b00);
            cpu_write(8'(4 * i + 2), s.offset, 2'b00);
            cpu_write(8'(4 * i + 3), {s.hflip, s.prio, s.pal, s.bank, 3'd0}, 2'b00);
        end
        if (row_term[r]) begin
            cpu_write(8'd16, 16'hFF00, 2'b00);
        end
    endtask

    task automatic build_expected(input int r);
        logic [11:0] px [0:LINE_PIXELS-1];
        logic [15:0] data;
        logic [3:0]  color;
        logic [8:0]  pos;
        sprite_t     s;
        int          i;
        int          w;
        int          k;
        int          rel;
        for (i = 0; i < LINE_PIXELS; i++) begin
            px[i] = '0;
        end
        // Later entries land on top
        for (i = 0; i < row_cnt[r]; i++) begin
            s = row_spr[r][i];
            if (row_line[r] >= int'(s.top) && row_line[r] < int'(s.bottom)) begin
                rel = row_line[r] - int'(s.top);
                for (w = 0; w < 4; w++) begin
                    data = gfx_word({s.bank, s.offset + 16'(4 * rel + w)});
                    for (k = 0; k < 4; k++) begin
                        // First pixel in the top nibble
                        color = data[15 - 4 * k -: 4];
                        if (s.hflip) begin
                            pos = s.x + 9'(15 - (4 * w + k));
                        end else begin
                            pos = s.x + 9'(4 * w + k);
                        end
                        if (color != 4'd0 && int'(pos) < LINE_PIXELS) begin
                            px[pos] = {s.pal, s.prio, color};
                        end
                    end
                end
            end
        end
        for (i = 0; i < LINE_PIXELS; i++) begin
            chk.load_pixel(i, px[i]);
        end
    endtask

    task automatic blank();
        lhbl = 1'b0;
        repeat (16) @(negedge clk);
    endtask

    task automatic active_line(input int pixels);
        int n;
        lhbl = 1'b1;
        for (n = 0; n < pixels; n++) begin
            pxl_cen = 1'b1;
            @(negedge clk);
            pxl_cen = 1'b0;
            @(negedge clk);
        end
    endtask

    task automatic run_row(input int r);
        int n;
        load_row(r);
        // Scanner targets vrender plus one
        vrender = 9'(row_line[r] - 1);
        hstart  = 1'b1;
        @(negedge clk);
        hstart = 1'b0;
        // Worst-case walk fits inside this window
        for (n = 0; n < SCAN_CYCLES; n++) begin
            @(negedge clk);
        end
        if (gfx_req) begin
            $display("Timeout in %s: drawer still fetching %0d cycles after hstart",
                     row_name[r], SCAN_CYCLES);
            timeouts++;
        end
        build_expected(r);
        chk.start_line(row_name[r]);
        // Halves swap here
        blank();
        active_line(LINE_PIXELS);
        repeat (4) @(negedge clk);
        chk.end_line();
    endtask

    initial begin
        int r;
        int n;
        clk      = 1'b0;
        arst_n   = 1'b0;
        cpu_cs   = 1'b0;
        cpu_we   = 1'b0;
        cpu_addr = '0;
        cpu_dout = '0;
        dsn      = 2'b11;
        hstart   = 1'b0;
        lhbl     = 1'b0;
        pxl_cen  = 1'b0;
        vrender  = '0;
        gfx_data = '0;
        gfx_ack  = 1'b0;
        gfx_busy = 1'b0;
        gfx_wait = 0;
        rng      = 32'd62;
        timeouts = 0;
        fill_table();
        repeat (16) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        // Zero spans never hit and never terminate
        for (n = 0; n < 256; n++) begin
            cpu_write(8'(n), 16'h0000, 2'b00);
        end
        cpu_lane_test();
        // Flush both line-buffer halves
        active_line(512);
        blank();
        active_line(512);
        for (r = 0; r < NROWS && timeouts == 0; r++) begin
            run_row(r);
        end
        $display("Result: %0d pixel errors, %0d cpu errors, %0d timeouts",
                 pix_errs, cpu_errs, timeouts);
        if (pix_errs == 0 && cpu_errs == 0 && timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
rtl/video_pkg.sv
rtl/obj_pkg.sv
rtl/obj_draw_if.sv
rtl/obj_ram.sv
rtl/obj_scan.sv
rtl/obj_draw.sv
rtl/obj_line_buffer.sv
rtl/obj_engine.sv
testbench/obj_checker.sv
testbench/tb_obj_engine.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the sprite engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_obj_engine -f files.f -o sim_obj_engine

./obj_dir/sim_obj_engine | tee sim.log

grep -q "All tests passed" sim.log
